// File: src/boolFuncPkg.sv
`default_nettype none

package boolFuncPkg;

    // boolean functions of seven inputs stored as truth tables
    // bit i holds f(i), bit k of i is variable k
    localparam int varCount = 7;
    localparam int funcBits = 1 << varCount;   // 128 table bits

    // variables reordered by the 24-way permutation set
    localparam int firstPermVar = 3;
    localparam int lastPermVar = 6;

    // weight of one permutation never exceeds funcBits,
    // so one bit beyond log2 is enough
    localparam int weightBits = $clog2(funcBits) + 1;   // 8

endpackage

`default_nettype wire

// File: src/permPipePkg.sv
`default_nettype none

package permPipePkg;

    // lane split of the 24 permutations
    localparam int laneCount = 4;
    localparam int permsPerLane = 6;
    localparam int totalPerms = laneCount * permsPerLane;

    // result widths unless the top level overrides them
    localparam int defaultSumWidth = 24;
    localparam int defaultCountWidth = 16;

    // batchDone sample to full adder tree output
    // decoder 1, lane weights 1, accumulator 1, adder tree 2
    localparam int coreLatency = 5;
    localparam int defaultExtraDelay = 2;   // output delay after the tree

endpackage

`default_nettype wire

// File: src/delayPipe.sv
`default_nettype none

module delayPipe #(
    parameter type dataType = logic,
    parameter int depth = 1
) (
    input  wire          clk,
    input  wire          rst,
    input  wire dataType din,
    output dataType      dout
);

    if (depth == 0) begin : genDirect
        assign dout = din;   // zero cycles requested
    end else begin : genChain
        dataType stages [depth];

        always_ff @(posedge clk) begin
            if (rst) begin
                for (int s = 0; s < depth; s++) begin
                    stages[s] <= '0;   // keeps a carried strobe low
                end
            end else begin
                stages[0] <= din;
                for (int s = 1; s < depth; s++) begin
                    stages[s] <= stages[s - 1];
                end
            end
        end

        assign dout = stages[depth - 1];
    end

endmodule

`default_nettype wire

// File: src/permuteDecoder.sv
`default_nettype none

module permuteDecoder (
    input  wire                                       clk,
    input  wire                                       rst,
    input  wire [boolFuncPkg::funcBits-1:0]           top,
    input  wire [boolFuncPkg::funcBits-1:0]           bot,
    input  wire                                       dataValid,
    input  wire                                       batchDone,
    output logic [boolFuncPkg::funcBits-1:0]          topQ,
    output logic [permPipePkg::totalPerms-1:0][boolFuncPkg::funcBits-1:0] permBots,
    output logic [permPipePkg::totalPerms-1:0]        validMask,
    output logic                                      itemValid,
    output logic                                      batchEnd
);

    // source bit index feeding bit idx of a permuted table
    // lane picks which variable trades places with var 3,
    // order picks one of six arrangements of vars 4..6
    function automatic int unsigned permSource(input int unsigned lane,
                                               input int unsigned order,
                                               input int unsigned idx);
        int unsigned lo;
        int unsigned varSel [3];
        int unsigned permBits;
        int unsigned mid;
        int unsigned swapVar;
        int unsigned res;
        lo = boolFuncPkg::firstPermVar + 1;
        case (order)
            1: varSel = '{lo, lo + 2, lo + 1};
            2: varSel = '{lo + 1, lo, lo + 2};
            3: varSel = '{lo + 1, lo + 2, lo};
            4: varSel = '{lo + 2, lo, lo + 1};
            5: varSel = '{lo + 2, lo + 1, lo};
            default: varSel = '{lo, lo + 1, lo + 2};
        endcase
        permBits = ((1 << (boolFuncPkg::lastPermVar + 1)) - 1) & ~((1 << lo) - 1);
        mid = idx & ~permBits;   // untouched variables pass straight
        for (int m = 0; m < 3; m++) begin
            mid |= ((idx >> varSel[m]) & 1) << (lo + m);
        end
        // base swap for this lane, lane 0 keeps var 3 in place
        swapVar = boolFuncPkg::firstPermVar + lane;
        res = mid;
        if (swapVar != boolFuncPkg::firstPermVar) begin
            res &= ~((1 << boolFuncPkg::firstPermVar) | (1 << swapVar));
            res |= ((mid >> swapVar) & 1) << boolFuncPkg::firstPermVar;
            res |= ((mid >> boolFuncPkg::firstPermVar) & 1) << swapVar;
        end
        return res;
    endfunction

    logic [permPipePkg::totalPerms-1:0][boolFuncPkg::funcBits-1:0] permNext;
    logic [permPipePkg::totalPerms-1:0] fits;

    // permutation p lives in lane p / 6, slot p % 6
    for (genvar p = 0; p < permPipePkg::totalPerms; p++) begin : genPerm
        for (genvar i = 0; i < boolFuncPkg::funcBits; i++) begin : genBit
            localparam int unsigned src = permSource(p / permPipePkg::permsPerLane,
                                                     p % permPipePkg::permsPerLane, i);
            assign permNext[p][i] = bot[src];   // pure rewiring
        end
        // every set bit of the permuted bot must be set in top
        assign fits[p] = ((permNext[p] & ~top) == '0);
    end

    // payload
    always_ff @(posedge clk) begin
        topQ <= top;
        permBots <= permNext;
    end

    // strobes and mask
    always_ff @(posedge clk) begin
        if (rst) begin
            validMask <= '0;
            itemValid <= 1'b0;
            batchEnd <= 1'b0;
        end else begin
            validMask <= dataValid ? fits : '0;   // no item, nothing counts
            itemValid <= dataValid;
            batchEnd <= batchDone;
        end
    end

endmodule

`default_nettype wire

// File: src/permuteLane.sv
`default_nettype none

module permuteLane #(
    parameter int sumWidth = permPipePkg::defaultSumWidth,
    parameter int countWidth = permPipePkg::defaultCountWidth
) (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire [boolFuncPkg::funcBits-1:0]      topQ,
    input  wire [permPipePkg::permsPerLane-1:0][boolFuncPkg::funcBits-1:0] permBots,
    input  wire [permPipePkg::permsPerLane-1:0]  validMask,
    input  wire                                  batchEnd,
    output logic [sumWidth-1:0]                  laneSum,
    output logic [countWidth-1:0]                laneCount,
    output logic                                 laneDone
);

    // six weights of up to 128 each, 768 max
    localparam int stageSumBits = boolFuncPkg::weightBits + $clog2(permPipePkg::permsPerLane);
    localparam int stageCountBits = $clog2(permPipePkg::permsPerLane + 1);

    logic [permPipePkg::permsPerLane-1:0][boolFuncPkg::weightBits-1:0] weights;
    logic [stageSumBits-1:0]   weightTotal;
    logic [stageCountBits-1:0] validTotal;

    logic [stageSumBits-1:0]   stageSum;
    logic [stageCountBits-1:0] stageCount;
    logic                      stageEnd;

    logic [sumWidth-1:0]       accSum;
    logic [countWidth-1:0]     accCount;
    logic [sumWidth-1:0]       nextSum;
    logic [countWidth-1:0]     nextCount;

    // weight is the number of top bits the permuted bot leaves clear
    always_comb begin
        weightTotal = '0;
        validTotal = '0;
        for (int k = 0; k < permPipePkg::permsPerLane; k++) begin
            if (validMask[k]) begin
                weights[k] = boolFuncPkg::weightBits'($countones(topQ & ~permBots[k]));
            end else begin
                weights[k] = '0;
            end
            weightTotal += stageSumBits'(weights[k]);
            validTotal += stageCountBits'(validMask[k]);
        end
    end

    // stage 1, per-item totals
    always_ff @(posedge clk) begin
        stageSum <= weightTotal;
        stageCount <= validTotal;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stageEnd <= 1'b0;
        end else begin
            stageEnd <= batchEnd;   // follows the closing item
        end
    end

    // stage 2, batch accumulation
    assign nextSum = accSum + sumWidth'(stageSum);
    assign nextCount = accCount + countWidth'(stageCount);

    always_ff @(posedge clk) begin
        if (rst) begin
            accSum <= '0;
            accCount <= '0;
            laneDone <= 1'b0;
        end else begin
            laneDone <= stageEnd;
            if (stageEnd) begin
                // closing item already went into nextSum
                accSum <= '0;
                accCount <= '0;
            end else begin
                accSum <= nextSum;
                accCount <= nextCount;
            end
        end
    end

    // published totals, valid while laneDone is high
    always_ff @(posedge clk) begin
        if (stageEnd) begin
            laneSum <= nextSum;
            laneCount <= nextCount;
        end
    end

endmodule

`default_nettype wire

// File: src/laneCombiner.sv
`default_nettype none

module laneCombiner #(
    parameter int sumWidth = permPipePkg::defaultSumWidth,
    parameter int countWidth = permPipePkg::defaultCountWidth,
    parameter int extraDelay = permPipePkg::defaultExtraDelay
) (
    input  wire                                          clk,
    input  wire                                          rst,
    input  wire [permPipePkg::laneCount-1:0][sumWidth-1:0]   laneSum,
    input  wire [permPipePkg::laneCount-1:0][countWidth-1:0] laneCount,
    input  wire                                          laneDone,
    output logic [sumWidth-1:0]                          pcoeffSum,
    output logic [countWidth-1:0]                        pcoeffCount,
    output logic                                         resultValid
);

    logic [1:0][sumWidth-1:0]   pairSum;
    logic [1:0][countWidth-1:0] pairCount;
    logic                       pairDone;
    logic [sumWidth-1:0]        fullSum;
    logic [countWidth-1:0]      fullCount;
    logic                       fullDone;
    logic [sumWidth-1:0]        sumDelayed;
    logic [countWidth-1:0]      countDelayed;
    logic                       doneDelayed;

    // adder tree, lanes 0+1 and 2+3 then both pairs
    always_ff @(posedge clk) begin
        pairSum[0] <= laneSum[0] + laneSum[1];
        pairSum[1] <= laneSum[2] + laneSum[3];
        pairCount[0] <= laneCount[0] + laneCount[1];
        pairCount[1] <= laneCount[2] + laneCount[3];
        fullSum <= pairSum[0] + pairSum[1];
        fullCount <= pairCount[0] + pairCount[1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pairDone <= 1'b0;
            fullDone <= 1'b0;
        end else begin
            pairDone <= laneDone;
            fullDone <= pairDone;
        end
    end

    // the hold register below is the last of the extraDelay cycles
    delayPipe #(.dataType(logic [sumWidth-1:0]), .depth(extraDelay - 1)) sumPipe (
        .clk(clk), .rst(rst), .din(fullSum), .dout(sumDelayed)
    );
    delayPipe #(.dataType(logic [countWidth-1:0]), .depth(extraDelay - 1)) countPipe (
        .clk(clk), .rst(rst), .din(fullCount), .dout(countDelayed)
    );
    delayPipe #(.dataType(logic), .depth(extraDelay - 1)) donePipe (
        .clk(clk), .rst(rst), .din(fullDone), .dout(doneDelayed)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            pcoeffSum <= '0;
            pcoeffCount <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= doneDelayed;   // single cycle pulse
            if (doneDelayed) begin
                pcoeffSum <= sumDelayed;
                pcoeffCount <= countDelayed;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pipeline24Pack.sv
`default_nettype none

// sums weights of all 24 permutations of variables 3..6 per batch
module pipeline24Pack #(
    parameter int sumWidth = permPipePkg::defaultSumWidth,
    parameter int countWidth = permPipePkg::defaultCountWidth,
    parameter int extraDelay = permPipePkg::defaultExtraDelay
) (
    input  wire                               clk,
    input  wire                               rst,
    input  wire [boolFuncPkg::funcBits-1:0]   top,
    input  wire [boolFuncPkg::funcBits-1:0]   bot,
    input  wire                               dataValid,
    input  wire                               batchDone,
    output logic [sumWidth-1:0]               pcoeffSum,
    output logic [countWidth-1:0]             pcoeffCount,
    output logic                              resultValid
);

    logic [boolFuncPkg::funcBits-1:0] topQ;
    logic [permPipePkg::totalPerms-1:0][boolFuncPkg::funcBits-1:0] permBots;
    logic [permPipePkg::totalPerms-1:0] validMask;
    logic itemValid;   // observed by the bound checks
    logic batchEnd;

    logic [permPipePkg::laneCount-1:0][sumWidth-1:0]   laneSum;
    logic [permPipePkg::laneCount-1:0][countWidth-1:0] laneCount;
    logic [permPipePkg::laneCount-1:0]                 laneDone;

    permuteDecoder decoder (
        .clk(clk),
        .rst(rst),
        .top(top),
        .bot(bot),
        .dataValid(dataValid),
        .batchDone(batchDone),
        .topQ(topQ),
        .permBots(permBots),
        .validMask(validMask),
        .itemValid(itemValid),
        .batchEnd(batchEnd)
    );

    // lane j gets permutations 6j .. 6j+5
    for (genvar j = 0; j < permPipePkg::laneCount; j++) begin : genLane
        permuteLane #(
            .sumWidth(sumWidth),
            .countWidth(countWidth)
        ) lane (
            .clk(clk),
            .rst(rst),
            .topQ(topQ),
            .permBots(permBots[j * permPipePkg::permsPerLane +: permPipePkg::permsPerLane]),
            .validMask(validMask[j * permPipePkg::permsPerLane +: permPipePkg::permsPerLane]),
            .batchEnd(batchEnd),
            .laneSum(laneSum[j]),
            .laneCount(laneCount[j]),
            .laneDone(laneDone[j])
        );
    end

    // all lanes finish together, lane 0 speaks for them
    laneCombiner #(
        .sumWidth(sumWidth),
        .countWidth(countWidth),
        .extraDelay(extraDelay)
    ) combiner (
        .clk(clk),
        .rst(rst),
        .laneSum(laneSum),
        .laneCount(laneCount),
        .laneDone(laneDone[0]),
        .pcoeffSum(pcoeffSum),
        .pcoeffCount(pcoeffCount),
        .resultValid(resultValid)
    );

endmodule

`default_nettype wire

// File: verification/pipeline24Pack_asserts.sv
`default_nettype none

module pipeline24PackAsserts #(
    parameter int sumWidth = permPipePkg::defaultSumWidth,
    parameter int countWidth = permPipePkg::defaultCountWidth,
    parameter int extraDelay = permPipePkg::defaultExtraDelay
) (
    input wire                                clk,
    input wire                                rst,
    input wire                                batchDone,
    input wire                                itemValid,
    input wire                                batchEnd,
    input wire [permPipePkg::laneCount-1:0]   laneDone,
    input wire                                resultValid,
    input wire [sumWidth-1:0]                 pcoeffSum,
    input wire [countWidth-1:0]               pcoeffCount
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int latency = permPipePkg::coreLatency + extraDelay;   // 7 by default

    int failures = 0;

    resetQuiet: assert property (@(posedge clk) rst |=> !resultValid)
        else begin
            $error("resultValid high while rst is asserted");
            failures++;
        end

    // decoder and lane strobes come out of reset low
    resetStrobes: assert property (@(posedge clk)
        rst |=> (!itemValid && !batchEnd && laneDone == '0))
        else begin
            $error("internal strobes high after a reset cycle");
            failures++;
        end

    // every closing strobe comes out exactly latency cycles later
    doneToResult: assert property (@(posedge clk) disable iff (rst)
        batchDone |-> ##latency resultValid)
        else begin
            $error("batchDone not followed by resultValid after %0d cycles", latency);
            failures++;
        end

    resultFromDone: assert property (@(posedge clk) disable iff (rst)
        resultValid |-> $past(batchDone, latency))
        else begin
            $error("resultValid without a batchDone %0d cycles earlier", latency);
            failures++;
        end

    holdOutputs: assert property (@(posedge clk) disable iff (rst)
        !resultValid |-> ($stable(pcoeffSum) && $stable(pcoeffCount)))
        else begin
            $error("result outputs changed between pulses");
            failures++;
        end

endmodule

bind pipeline24Pack pipeline24PackAsserts #(
    .sumWidth(sumWidth),
    .countWidth(countWidth),
    .extraDelay(extraDelay)
) checks (
    .clk(clk),
    .rst(rst),
    .batchDone(batchDone),
    .itemValid(itemValid),
    .batchEnd(batchEnd),
    .laneDone(laneDone),
    .resultValid(resultValid),
    .pcoeffSum(pcoeffSum),
    .pcoeffCount(pcoeffCount)
);

`default_nettype wire

// File: verification/pipeline24PackTb.sv
`default_nettype none

module pipeline24PackTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int tableBits = boolFuncPkg::funcBits;
    localparam int resetCycles = 16;
    // items and closings of tests 1 to 6, then each drain
    localparam int stimulusCycles = 11 + 1 + 3 + 6 * 8 + 5 + 19;
    localparam int drainCycles = 11 * 12;   // six random batches plus five other tests
    localparam int cycleLimit = resetCycles + stimulusCycles + drainCycles + 100;
    localparam int resultDelay = 7;   // drive edge to the negedge that sees the pulse

    logic clk;
    logic rst;
    logic [tableBits-1:0] top;
    logic [tableBits-1:0] bot;
    logic dataValid;
    logic batchDone;
    logic [permPipePkg::defaultSumWidth-1:0] pcoeffSum;
    logic [permPipePkg::defaultCountWidth-1:0] pcoeffCount;
    logic resultValid;

    int cycles = 0;
    int modelSum = 0;
    int modelCount = 0;
    int valueErrors = 0;
    int missingResults = 0;
    int unexpectedResults = 0;
    int lateResults = 0;
    int checkedResults = 0;
    int seedDummy;
    string curTest = "none";

    // pending results, oldest first
    int expSumQ[$];
    int expCountQ[$];
    int dueQ[$];
    string nameQ[$];

    pipeline24Pack dut_i (
        .clk(clk),
        .rst(rst),
        .top(top),
        .bot(bot),
        .dataValid(dataValid),
        .batchDone(batchDone),
        .pcoeffSum(pcoeffSum),
        .pcoeffCount(pcoeffCount),
        .resultValid(resultValid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // code packs the image of variables 3..6 as four 2-bit fields
    function automatic logic [tableBits-1:0] permuteTable(input logic [tableBits-1:0] b,
                                                          input int code);
        logic [tableBits-1:0] moved;
        int src;
        for (int i = 0; i < tableBits; i++) begin
            src = i & 7;   // variables 0..2 stay
            for (int k = 0; k < 4; k++) begin
                if ((i >> (3 + k)) & 1) begin
                    src |= 1 << (3 + ((code >> (2 * k)) & 3));
                end
            end
            moved[i] = b[src];
        end
        return moved;
    endfunction

    // all 24 bijections, weight counts top bits left clear
    function automatic void addItemToModel(input logic [tableBits-1:0] t,
                                           input logic [tableBits-1:0] b);
        logic [tableBits-1:0] moved;
        int used;
        for (int code = 0; code < 256; code++) begin
            used = 0;
            for (int k = 0; k < 4; k++) begin
                used |= 1 << ((code >> (2 * k)) & 3);
            end
            if (used == 15) begin
                moved = permuteTable(b, code);
                if ((moved & ~t) == '0) begin
                    modelCount++;
                    modelSum += $countones(t & ~moved);
                end
            end
        end
    endfunction

    function automatic logic [tableBits-1:0] randomTable();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic closeBatch();
        expSumQ.push_back(modelSum);
        expCountQ.push_back(modelCount);
        dueQ.push_back(cycles + resultDelay);
        nameQ.push_back(curTest);
        modelSum = 0;
        modelCount = 0;
    endtask

    task automatic sendCycle(input logic valid, input logic done,
                             input logic [tableBits-1:0] t, input logic [tableBits-1:0] b);
        @(posedge clk);
        #2;
        dataValid = valid;
        batchDone = done;
        top = t;
        bot = b;
        if (valid) begin
            addItemToModel(t, b);   // closing item goes in first
        end
        if (done) begin
            closeBatch();
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) sendCycle(1'b0, 1'b0, '0, '0);
    endtask

    task automatic waitDrain();
        idleCycles(1);
        while (dueQ.size() > 0) @(posedge clk);
        idleCycles(2);
    endtask

    // compare each pulse against the oldest pending batch
    always @(negedge clk) begin
        if (dueQ.size() > 0 && dueQ[0] < cycles) begin
            $display("missing result in %s, no pulse by cycle %0d", nameQ[0], dueQ[0]);
            missingResults++;
            void'(expSumQ.pop_front());
            void'(expCountQ.pop_front());
            void'(dueQ.pop_front());
            void'(nameQ.pop_front());
        end
        if (resultValid === 1'b1) begin
            if (dueQ.size() == 0) begin
                $display("unexpected result at cycle %0d with no batch pending", cycles);
                unexpectedResults++;
            end else begin
                checkedResults++;
                if (dueQ[0] != cycles) begin
                    $display("result of %s came at cycle %0d instead of %0d",
                             nameQ[0], cycles, dueQ[0]);
                    lateResults++;
                end
                if (int'(pcoeffSum) != expSumQ[0]) begin
                    $display("ERR %s sum expected %0d actual %0d",
                             nameQ[0], expSumQ[0], pcoeffSum);
                    valueErrors++;
                end
                if (int'(pcoeffCount) != expCountQ[0]) begin
                    $display("ERR %s count expected %0d actual %0d",
                             nameQ[0], expCountQ[0], pcoeffCount);
                    valueErrors++;
                end
                void'(expSumQ.pop_front());
                void'(expCountQ.pop_front());
                void'(dueQ.pop_front());
                void'(nameQ.pop_front());
            end
        end
    end

    task automatic printCounts();
        $display({"checked %0d results, errors %0d value %0d missing %0d unexpected ",
                  "%0d late %0d assertion"},
                 checkedResults, valueErrors, missingResults, unexpectedResults, lateResults,
                 dut_i.checks.failures);
    endtask

    task automatic testIdleThenEmpty();
        curTest = "idleThenEmpty";
        idleCycles(10);   // no pulse allowed here
        sendCycle(1'b0, 1'b1, '0, '0);
        waitDrain();
    endtask

    task automatic testAllFit();
        curTest = "allFit";
        sendCycle(1'b1, 1'b1, '1, '0);   // 24 perms, 128 each
        waitDrain();
    endtask

    task automatic testSparseBots();
        logic [tableBits-1:0] t;
        logic [tableBits-1:0] b;
        curTest = "sparseBots";
        // vars 0,3,4 set, top holds two points of its orbit
        t = '0;
        t[25] = 1'b1;
        t[81] = 1'b1;
        t[0] = 1'b1;
        b = '0;
        b[25] = 1'b1;
        sendCycle(1'b1, 1'b1, t, b);
        t = '0;
        t[64] = 1'b1;
        b = '0;
        b[8] = 1'b1;
        sendCycle(1'b1, 1'b1, t, b);
        t = {64'h0, {64{1'b1}}};   // lower half, var 6 clear
        b = '0;
        b[8] = 1'b1;
        b[72] = 1'b1;
        sendCycle(1'b1, 1'b1, t, b);
        waitDrain();
    endtask

    task automatic testRandomBatches();
        int size;
        logic [tableBits-1:0] t;
        logic [tableBits-1:0] b;
        curTest = "randomBatches";
        for (int n = 0; n < 6; n++) begin
            size = 1 + ($urandom % 8);
            for (int k = 0; k < size; k++) begin
                t = randomTable();
                b = ($urandom % 2) ? (t & randomTable()) : randomTable();
                sendCycle(1'b1, k == size - 1, t, b);
            end
            waitDrain();
        end
    endtask

    task automatic testBackToBack();
        curTest = "backToBack";
        sendCycle(1'b0, 1'b1, '0, '0);
        sendCycle(1'b0, 1'b1, '0, '0);
        sendCycle(1'b1, 1'b1, '1, '0);
        sendCycle(1'b1, 1'b1, '1, randomTable() & {64'h0, {64{1'b1}}});
        sendCycle(1'b0, 1'b1, '0, '0);   // must read zero again
        waitDrain();
    endtask

    task automatic testStream();
        int sizes [4];
        logic [tableBits-1:0] t;
        curTest = "stream";
        sizes = '{5, 3, 7, 4};
        for (int n = 0; n < 4; n++) begin
            for (int k = 0; k < sizes[n]; k++) begin
                t = randomTable();
                sendCycle(1'b1, k == sizes[n] - 1, t, (k % 2) ? (t & randomTable()) : '0);
            end
        end
        waitDrain();
    endtask

    // watchdog
    initial begin
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped at cycle limit %0d before the tests finished", cycleLimit);
        printCounts();
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seedDummy = $urandom(32'hb11b_cb29);
        rst = 1'b1;
        top = '0;
        bot = '0;
        dataValid = 1'b0;
        batchDone = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #2;
        rst = 1'b0;

        testIdleThenEmpty();
        testAllFit();
        testSparseBots();
        testRandomBatches();
        testBackToBack();
        testStream();

        printCounts();
        if (valueErrors + missingResults + unexpectedResults + lateResults
                + dut_i.checks.failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
src/boolFuncPkg.sv
src/permPipePkg.sv
src/delayPipe.sv
src/permuteDecoder.sv
src/permuteLane.sv
src/laneCombiner.sv
src/pipeline24Pack.sv
verification/pipeline24Pack_asserts.sv
verification/pipeline24PackTb.sv
